// ==== av_timing_pkg.sv ====
//////////////////////////////////////////////////
// raster geometry and i2s framing constants
// shared by the video generator, the i2s
// transmitter and the testbench checkers
//////////////////////////////////////////////////

package av_timing_pkg;

    //////////////////////////////////////////////////
    // video raster, 320x240 visible inside 400x512
    //////////////////////////////////////////////////

    // pixel clocks per line, visible width, first visible column
    localparam int h_total  = 400;
    localparam int h_active = 320;
    localparam int h_bporch = 10;
    // lines per frame, visible lines, first visible line
    localparam int v_total  = 512;
    localparam int v_active = 240;
    localparam int v_bporch = 10;
    // hsync lands a few clocks after vsync
    localparam int hs_col   = 3;
    // wide enough for 0..511
    localparam int coord_w  = 10;

    //////////////////////////////////////////////////
    // i2s framing
    //////////////////////////////////////////////////

    localparam int sclk_div     = 4;
    localparam int slots_per_ch = 32;
    localparam int sample_w     = 16;

    // channel currently on the wire, lrck low for left
    typedef enum logic {
        chan_left  = 1'b0,
        chan_right = 1'b1
    } i2s_chan_e;

endpackage

// ==== av_regs_pkg.sv ====
//////////////////////////////////////////////////
// apb register map of the core
// addresses, field widths, reset values and the
// bus phase encoding used by the slave
//////////////////////////////////////////////////

package av_regs_pkg;

    localparam int apb_addr_w  = 8;
    localparam int apb_data_w  = 32;
    localparam int rgb_w       = 24;
    localparam int frame_cnt_w = 16;

    // register offsets, byte addressed
    typedef enum logic [apb_addr_w-1:0] {
        reg_ctrl      = 8'h00,
        reg_fill_rgb  = 8'h04,
        reg_sample_l  = 8'h08,
        reg_sample_r  = 8'h0c,
        reg_frame_cnt = 8'h10
    } reg_addr_e;

    // control register fields
    localparam int ctrl_video_en_bit = 0;
    localparam int ctrl_audio_en_bit = 1;

    // dark grey, 60 in every colour byte
    localparam logic [rgb_w-1:0] fill_rgb_reset = {3{8'd60}};

    // bus phase seen in the previous clock
    typedef enum logic [1:0] {
        phase_idle   = 2'd0,
        phase_setup  = 2'd1,
        phase_access = 2'd2
    } apb_phase_e;

endpackage

// ==== apb_regs.sv ====
//////////////////////////////////////////////////
// apb slave holding control, fill colour and the
// two audio sample registers, zero wait states
// frame counter is read back from the video side
//////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_regs (
    input  logic                                 audgen_mclk,
    input  logic                                 reset_n,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [av_regs_pkg::apb_addr_w-1:0]   paddr,
    input  logic [av_regs_pkg::apb_data_w-1:0]   pwdata,
    output logic [av_regs_pkg::apb_data_w-1:0]   prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  logic [av_regs_pkg::frame_cnt_w-1:0]  frame_cnt,
    output logic                                 video_en,
    output logic                                 audio_en,
    output logic [av_regs_pkg::rgb_w-1:0]        fill_rgb,
    output logic [av_timing_pkg::sample_w-1:0]   sample_l,
    output logic [av_timing_pkg::sample_w-1:0]   sample_r
);

    av_regs_pkg::apb_phase_e                 phase_q;
    logic [av_regs_pkg::apb_data_w-1:0]      ctrl_q;
    logic [av_regs_pkg::rgb_w-1:0]           fill_rgb_q;
    logic [av_timing_pkg::sample_w-1:0]      sample_l_q;
    logic [av_timing_pkg::sample_w-1:0]      sample_r_q;
    logic [av_regs_pkg::apb_data_w-1:0]      rd_data;
    logic                                    addr_hit;
    logic                                    addr_ro;
    logic                                    access;
    logic                                    wr_en;

    //////////////////////////////////////////////////
    // bus phase tracking
    //////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            phase_q <= av_regs_pkg::phase_idle;
        end else if (!psel) begin
            phase_q <= av_regs_pkg::phase_idle;
        end else if (!penable) begin
            phase_q <= av_regs_pkg::phase_setup;
        end else begin
            phase_q <= av_regs_pkg::phase_access;
        end
    end

    // access phase only counts right after a setup phase
    assign access = psel && penable && (phase_q == av_regs_pkg::phase_setup);

    //////////////////////////////////////////////////
    // address decode and read mux
    //////////////////////////////////////////////////

    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        rd_data  = '0;
        case (paddr)
            av_regs_pkg::reg_ctrl:     rd_data = ctrl_q;
            av_regs_pkg::reg_fill_rgb: rd_data = av_regs_pkg::apb_data_w'(fill_rgb_q);
            av_regs_pkg::reg_sample_l: rd_data = av_regs_pkg::apb_data_w'(sample_l_q);
            av_regs_pkg::reg_sample_r: rd_data = av_regs_pkg::apb_data_w'(sample_r_q);
            av_regs_pkg::reg_frame_cnt: begin
                // read only, owned by the video generator
                rd_data = av_regs_pkg::apb_data_w'(frame_cnt);
                addr_ro = 1'b1;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    // unmapped reads give zero
    assign prdata  = (psel && !pwrite) ? rd_data : '0;
    assign pready  = 1'b1;
    assign pslverr = access && (!addr_hit || (pwrite && addr_ro));
    assign wr_en   = access && pwrite && addr_hit && !addr_ro;

    //////////////////////////////////////////////////
    // register file
    //////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            ctrl_q     <= '0;
            fill_rgb_q <= av_regs_pkg::fill_rgb_reset;
            sample_l_q <= '0;
            sample_r_q <= '0;
        end else if (wr_en) begin
            case (paddr)
                av_regs_pkg::reg_ctrl:     ctrl_q     <= pwdata;
                av_regs_pkg::reg_fill_rgb: fill_rgb_q <= pwdata[av_regs_pkg::rgb_w-1:0];
                av_regs_pkg::reg_sample_l: sample_l_q <= pwdata[av_timing_pkg::sample_w-1:0];
                av_regs_pkg::reg_sample_r: sample_r_q <= pwdata[av_timing_pkg::sample_w-1:0];
                default: ;
            endcase
        end
    end

    // fields out to the generators
    assign video_en = ctrl_q[av_regs_pkg::ctrl_video_en_bit];
    assign audio_en = ctrl_q[av_regs_pkg::ctrl_audio_en_bit];
    assign fill_rgb = fill_rgb_q;
    assign sample_l = sample_l_q;
    assign sample_r = sample_r_q;

endmodule

// ==== video_timing.sv ====
//////////////////////////////////////////////////
// video timing for 320x240 in a 400x512 raster
// registered sync, data enable and fill colour,
// one clock behind the raster counters
//////////////////////////////////////////////////

`timescale 1ns/1ps

module video_timing (
    input  logic                                 audgen_mclk,
    input  logic                                 reset_n,
    input  logic                                 video_en,
    input  logic [av_regs_pkg::rgb_w-1:0]        fill_rgb,
    output logic [av_regs_pkg::rgb_w-1:0]        video_rgb,
    output logic                                 video_de,
    output logic                                 video_vs,
    output logic                                 video_hs,
    output logic [av_regs_pkg::frame_cnt_w-1:0]  frame_cnt
);

    logic [av_timing_pkg::coord_w-1:0]  x_q;
    logic [av_timing_pkg::coord_w-1:0]  y_q;
    logic                               x_last;
    logic                               y_last;
    logic                               h_active;
    logic                               v_active;

    //////////////////////////////////////////////////
    // raster decode
    //////////////////////////////////////////////////

    assign x_last = (x_q == av_timing_pkg::coord_w'(av_timing_pkg::h_total - 1));
    assign y_last = (y_q == av_timing_pkg::coord_w'(av_timing_pkg::v_total - 1));

    // visible window, columns 10..329 and lines 10..249
    assign h_active = (x_q >= av_timing_pkg::coord_w'(av_timing_pkg::h_bporch)) &&
                      (x_q <  av_timing_pkg::coord_w'(av_timing_pkg::h_bporch +
                                                     av_timing_pkg::h_active));
    assign v_active = (y_q >= av_timing_pkg::coord_w'(av_timing_pkg::v_bporch)) &&
                      (y_q <  av_timing_pkg::coord_w'(av_timing_pkg::v_bporch +
                                                     av_timing_pkg::v_active));

    //////////////////////////////////////////////////
    // counters and registered outputs
    //////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_q       <= '0;
            y_q       <= '0;
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
            frame_cnt <= '0;
        end else begin
            // column wraps every line, line wraps every frame
            if (x_last) begin
                x_q <= '0;
                if (y_last) begin
                    y_q <= '0;
                end else begin
                    y_q <= y_q + 1'b1;
                end
            end else begin
                x_q <= x_q + 1'b1;
            end

            // vsync at the very first pixel of the frame, in the back porch
            video_vs <= (x_q == '0) && (y_q == '0);
            if ((x_q == '0) && (y_q == '0)) begin
                frame_cnt <= frame_cnt + 1'b1;
            end

            // hsync a few clocks later so it never coincides with vsync
            video_hs <= (x_q == av_timing_pkg::coord_w'(av_timing_pkg::hs_col));

            video_de <= h_active && v_active;
            // black outside the window or with video off
            if (h_active && v_active && video_en) begin
                video_rgb <= fill_rgb;
            end else begin
                video_rgb <= '0;
            end
        end
    end

endmodule

// ==== i2s_tx.sv ====
//////////////////////////////////////////////////
// i2s transmitter with the bit clock at mclk / 4
// 32 slots per channel, 16 sample bits msb first
// then zero padding, both samples taken per pair
//////////////////////////////////////////////////

`timescale 1ns/1ps

module i2s_tx (
    input  logic                                audgen_mclk,
    input  logic                                reset_n,
    input  logic                                audio_en,
    input  logic [av_timing_pkg::sample_w-1:0]  sample_l,
    input  logic [av_timing_pkg::sample_w-1:0]  sample_r,
    output logic                                audio_sclk,
    output logic                                audio_lrck,
    output logic                                audio_dac
);

    logic [$clog2(av_timing_pkg::sclk_div)-1:0]     div_q;
    logic [$clog2(av_timing_pkg::slots_per_ch)-1:0] slot_q;
    av_timing_pkg::i2s_chan_e                       chan_q;
    logic [av_timing_pkg::sample_w-1:0]             shift_q;
    logic [av_timing_pkg::sample_w-1:0]             hold_r_q;
    logic                                           fall_en;
    logic                                           chan_start;

    // sclk is the divider msb so low for counts 0,1 and high for 2,3
    assign audio_sclk = div_q[$clog2(av_timing_pkg::sclk_div)-1];
    // next clock edge brings sclk low
    assign fall_en    = (div_q ==
                         ($clog2(av_timing_pkg::sclk_div))'(av_timing_pkg::sclk_div - 1));
    assign chan_start = (slot_q ==
                         ($clog2(av_timing_pkg::slots_per_ch))'(av_timing_pkg::slots_per_ch - 1));

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // slot counter, channel and serial data
    //////////////////////////////////////////////////

    // reset parks on the last right slot so the first falling edge opens a left channel
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_q     <= '1;
            chan_q     <= av_timing_pkg::chan_right;
            audio_lrck <= 1'b0;
            audio_dac  <= 1'b0;
        end else if (fall_en) begin
            slot_q <= slot_q + 1'b1;
            if (chan_start) begin
                if (chan_q == av_timing_pkg::chan_right) begin
                    chan_q     <= av_timing_pkg::chan_left;
                    audio_lrck <= 1'b0;
                    audio_dac  <= audio_en && sample_l[av_timing_pkg::sample_w-1];
                end else begin
                    chan_q     <= av_timing_pkg::chan_right;
                    audio_lrck <= 1'b1;
                    audio_dac  <= audio_en && hold_r_q[av_timing_pkg::sample_w-1];
                end
            end else begin
                // shifter runs dry after 16 slots and gives the zero pad
                audio_dac <= audio_en && shift_q[av_timing_pkg::sample_w-2];
            end
        end
    end

    // sample payload
    always_ff @(posedge audgen_mclk) begin
        if (fall_en) begin
            if (chan_start && (chan_q == av_timing_pkg::chan_right)) begin
                // left opens the pair and right waits for its turn
                shift_q  <= sample_l;
                hold_r_q <= sample_r;
            end else if (chan_start) begin
                shift_q <= hold_r_q;
            end else begin
                shift_q <= {shift_q[av_timing_pkg::sample_w-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== av_core_top.sv ====
//////////////////////////////////////////////////
// core top level, apb registers driving the
// video pattern generator and the i2s output
//////////////////////////////////////////////////

`timescale 1ns/1ps

module av_core_top (
    input  logic                                audgen_mclk,
    input  logic                                reset_n,
    // apb slave port
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [av_regs_pkg::apb_addr_w-1:0]  paddr,
    input  logic [av_regs_pkg::apb_data_w-1:0]  pwdata,
    output logic [av_regs_pkg::apb_data_w-1:0]  prdata,
    output logic                                pready,
    output logic                                pslverr,
    // video out
    output logic [av_regs_pkg::rgb_w-1:0]       video_rgb,
    output logic                                video_de,
    output logic                                video_vs,
    output logic                                video_hs,
    // i2s out
    output logic                                audio_sclk,
    output logic                                audio_lrck,
    output logic                                audio_dac
);

    logic                                 video_en;
    logic                                 audio_en;
    logic [av_regs_pkg::rgb_w-1:0]        fill_rgb;
    logic [av_timing_pkg::sample_w-1:0]   sample_l;
    logic [av_timing_pkg::sample_w-1:0]   sample_r;
    logic [av_regs_pkg::frame_cnt_w-1:0]  frame_cnt;

    apb_regs u_apb_regs (
        .audgen_mclk(audgen_mclk), .reset_n(reset_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .frame_cnt(frame_cnt), .video_en(video_en), .audio_en(audio_en),
        .fill_rgb(fill_rgb), .sample_l(sample_l), .sample_r(sample_r)
    );

    video_timing u_video_timing (
        .audgen_mclk(audgen_mclk), .reset_n(reset_n),
        .video_en(video_en), .fill_rgb(fill_rgb), .video_rgb(video_rgb),
        .video_de(video_de), .video_vs(video_vs), .video_hs(video_hs),
        .frame_cnt(frame_cnt)
    );

    i2s_tx u_i2s_tx (
        .audgen_mclk(audgen_mclk), .reset_n(reset_n),
        .audio_en(audio_en), .sample_l(sample_l), .sample_r(sample_r),
        .audio_sclk(audio_sclk), .audio_lrck(audio_lrck), .audio_dac(audio_dac)
    );

endmodule

// ==== tb_av_core.sv ====
//////////////////////////////////////////////////
// self-checking testbench for the av core
// apb register tests, raster and pixel monitors
// and an i2s slot checker, run with vlog.f
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_av_core;

    logic        audgen_mclk;
    logic        reset_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_vs;
    logic        video_hs;
    logic        audio_sclk;
    logic        audio_lrck;
    logic        audio_dac;

    // register model updated as each write lands
    logic [31:0] model_ctrl = '0;
    logic [23:0] model_fill = av_regs_pkg::fill_rgb_reset;
    logic [15:0] model_l = '0;
    logic [15:0] model_r = '0;
    // model as seen by the dut on the coming rising edge
    logic        lag_ven = 1'b0;
    logic        lag_aen = 1'b0;
    logic [23:0] lag_fill = av_regs_pkg::fill_rgb_reset;
    logic [15:0] lag_l = '0;
    logic [15:0] lag_r = '0;
    logic [31:0] lfsr_q = 32'ha0d3;

    int cyc = 0;
    int err_reg = 0;
    int err_vid = 0;
    int err_aud = 0;
    // video monitor state
    int hs_cyc = 0;
    int vs_cyc = 0;
    int vs_count = 0;
    int line_idx = -1;
    int de_run = 0;
    int de_lines = 0;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    logic de_prev = 1'b0;
    // audio monitor state
    int sclk_cyc = 0;
    int slot = av_timing_pkg::slots_per_ch - 1;
    logic sclk_fell = 1'b0;
    logic sclk_seen = 1'b0;
    logic lrck_prev = 1'b1;
    logic snap_en;
    logic [15:0] snap_l;
    logic [15:0] snap_r;
    logic [15:0] cur_l;
    logic [15:0] cur_r;

    av_core_top UUT (
        .audgen_mclk(audgen_mclk), .reset_n(reset_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .video_rgb(video_rgb), .video_de(video_de), .video_vs(video_vs),
        .video_hs(video_hs), .audio_sclk(audio_sclk), .audio_lrck(audio_lrck),
        .audio_dac(audio_dac)
    );

    initial begin
        audgen_mclk = 1'b0;
        forever #4 audgen_mclk = ~audgen_mclk;
    end

    //////////////////////////////////////////////////
    // stimulus helpers and reference functions
    //////////////////////////////////////////////////

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
    endtask

    // msb first for 16 slots then zero pad and all zero when disabled
    function automatic logic slot_bit(input logic en, input logic [15:0] s, input int k);
        logic [15:0] t;
        t = s << k;
        return en && (k < av_timing_pkg::sample_w) && t[15];
    endfunction

    // fill colour inside the window when enabled and black elsewhere
    function automatic logic [23:0] pixel_ref(input logic en, input logic [23:0] fill,
                                              input logic de);
        return (en && de) ? fill : 24'h0;
    endfunction

    task automatic log_error(input int area, input string msg);
        case (area)
            0: err_reg++;
            1: err_vid++;
            default: err_aud++;
        endcase
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // setup phase, access phase, then idle
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(posedge audgen_mclk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge audgen_mclk);
        penable <= 1'b1;
        @(negedge audgen_mclk);
        if (!pready) log_error(0, "pready low in write access");
        if (pslverr !== exp_err) log_error(0, $sformatf("write %h pslverr %b", addr, pslverr));
        @(posedge audgen_mclk);
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        // register takes the value on this edge
        case (addr)
            av_regs_pkg::reg_ctrl:     model_ctrl = data;
            av_regs_pkg::reg_fill_rgb: model_fill = data[23:0];
            av_regs_pkg::reg_sample_l: model_l = data[15:0];
            av_regs_pkg::reg_sample_r: model_r = data[15:0];
            default: ;
        endcase
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp_data,
                              input logic exp_err);
        @(posedge audgen_mclk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge audgen_mclk);
        penable <= 1'b1;
        @(negedge audgen_mclk);
        if (!pready) log_error(0, "pready low in read access");
        if (pslverr !== exp_err) log_error(0, $sformatf("read %h pslverr %b", addr, pslverr));
        if (prdata !== exp_data) begin
            log_error(0, $sformatf("read %h got %h expected %h", addr, prdata, exp_data));
        end
        @(posedge audgen_mclk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    //////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////

    always @(posedge audgen_mclk) begin
        cyc = cyc + 1;
        // two frames plus margin for the register and audio tests
        if (cyc >= 2 * av_timing_pkg::h_total * av_timing_pkg::v_total + 40400) begin
            $display("timeout: the run did not finish within %0d cycles", cyc);
            $display("tests failed");
            $finish;
        end
    end

    // outputs settled half a cycle after the edge
    always @(negedge audgen_mclk) begin
        if (reset_n) begin
            if (video_rgb !== pixel_ref(lag_ven, lag_fill, video_de)) begin
                log_error(1, $sformatf("pixel %h, en %b fill %h de %b", video_rgb,
                                       lag_ven, lag_fill, video_de));
            end
            if (video_hs) begin
                if (hs_prev) log_error(1, "hsync wider than one cycle");
                if (hs_cyc > 0 && cyc - hs_cyc != av_timing_pkg::h_total) begin
                    log_error(1, $sformatf("hsync period %0d", cyc - hs_cyc));
                end
                hs_cyc = cyc;
                line_idx++;
            end
            if (video_vs) begin
                if (vs_prev) log_error(1, "vsync wider than one cycle");
                // a whole frame lies behind every pulse but the first
                if (vs_count > 0) begin
                    if (cyc - vs_cyc != av_timing_pkg::h_total * av_timing_pkg::v_total) begin
                        log_error(1, $sformatf("vsync period %0d", cyc - vs_cyc));
                    end
                    if (de_lines != av_timing_pkg::v_active) begin
                        log_error(1, $sformatf("%0d lines with data enable", de_lines));
                    end
                end
                vs_cyc = cyc;
                vs_count++;
                de_lines = 0;
                line_idx = -1;
            end
            if (video_de) begin
                // window opens 7 clocks after hsync on lines 10..249
                if (!de_prev && (line_idx < av_timing_pkg::v_bporch ||
                        line_idx >= av_timing_pkg::v_bporch + av_timing_pkg::v_active ||
                        cyc - hs_cyc != av_timing_pkg::h_bporch - av_timing_pkg::hs_col)) begin
                    log_error(1, $sformatf("data enable at line %0d", line_idx));
                end
                de_run++;
            end else if (de_prev) begin
                if (de_run != av_timing_pkg::h_active) begin
                    log_error(1, $sformatf("data enable run of %0d", de_run));
                end
                de_lines++;
                de_run = 0;
            end
            hs_prev = video_hs;
            vs_prev = video_vs;
            de_prev = video_de;
            lag_ven = model_ctrl[av_regs_pkg::ctrl_video_en_bit];
            lag_aen = model_ctrl[av_regs_pkg::ctrl_audio_en_bit];
            lag_fill = model_fill;
            lag_l = model_l;
            lag_r = model_r;
        end
    end

    // register values the transmitter used on this falling edge
    always @(negedge audio_sclk) begin
        if (reset_n) begin
            snap_en = lag_aen;
            snap_l = lag_l;
            snap_r = lag_r;
            sclk_fell = 1'b1;
        end
    end

    // dac and lrck are mid-bit on the rising edge
    always @(posedge audio_sclk) begin
        if (sclk_fell) begin
            if (sclk_seen && cyc - sclk_cyc != av_timing_pkg::sclk_div) begin
                log_error(2, $sformatf("bit clock period %0d", cyc - sclk_cyc));
            end
            sclk_cyc = cyc;
            sclk_seen = 1'b1;
            if (audio_lrck != lrck_prev) begin
                if (slot != av_timing_pkg::slots_per_ch - 1) begin
                    log_error(2, $sformatf("lrck toggled after %0d slots", slot + 1));
                end
                slot = 0;
                // pair latched at the start of the left channel
                if (!audio_lrck) begin
                    cur_l = snap_l;
                    cur_r = snap_r;
                end
            end else begin
                slot++;
                if (slot >= av_timing_pkg::slots_per_ch) log_error(2, "lrck stuck");
            end
            if (audio_dac !== slot_bit(snap_en, audio_lrck ? cur_r : cur_l, slot)) begin
                log_error(2, $sformatf("dac %b in slot %0d, lrck %b", audio_dac, slot,
                                       audio_lrck));
            end
            lrck_prev = audio_lrck;
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        reset_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        repeat (5) @(posedge audgen_mclk);
        reset_n <= 1'b1;

        // reset values then random read-back
        read_check(av_regs_pkg::reg_ctrl, 32'h0, 1'b0);
        read_check(av_regs_pkg::reg_fill_rgb, {8'h0, av_regs_pkg::fill_rgb_reset}, 1'b0);
        read_check(av_regs_pkg::reg_sample_l, 32'h0, 1'b0);
        read_check(av_regs_pkg::reg_sample_r, 32'h0, 1'b0);
        draw_bits(30, r);
        apb_write(av_regs_pkg::reg_ctrl, {r[29:0], 2'b11}, 1'b0);
        read_check(av_regs_pkg::reg_ctrl, model_ctrl, 1'b0);
        for (int i = 0; i < 6; i++) begin
            draw_bits(32, r);
            apb_write(av_regs_pkg::reg_fill_rgb, r, 1'b0);
            read_check(av_regs_pkg::reg_fill_rgb, {8'h0, model_fill}, 1'b0);
            draw_bits(32, r);
            apb_write(av_regs_pkg::reg_sample_l, r, 1'b0);
            read_check(av_regs_pkg::reg_sample_l, {16'h0, model_l}, 1'b0);
            draw_bits(32, r);
            apb_write(av_regs_pkg::reg_sample_r, r, 1'b0);
            read_check(av_regs_pkg::reg_sample_r, {16'h0, model_r}, 1'b0);
            // two left starts so each pair goes out whole
            @(negedge audio_lrck);
            @(negedge audio_lrck);
        end

        // unmapped and read-only targets
        read_check(8'h14, 32'h0, 1'b1);
        apb_write(8'h40, 32'hffff_ffff, 1'b1);
        read_check(av_regs_pkg::reg_ctrl, model_ctrl, 1'b0);
        apb_write(av_regs_pkg::reg_frame_cnt, 32'h0000_abcd, 1'b1);
        read_check(av_regs_pkg::reg_frame_cnt, 32'(vs_count), 1'b0);

        // audio off gives silent slots then back on
        apb_write(av_regs_pkg::reg_ctrl, model_ctrl & ~32'h2, 1'b0);
        @(negedge audio_lrck);
        @(negedge audio_lrck);
        apb_write(av_regs_pkg::reg_ctrl, model_ctrl | 32'h2, 1'b0);
        @(negedge audio_lrck);
        @(negedge audio_lrck);

        // frame count away from the vsync edge then video off for a frame
        while (vs_count < 2) @(posedge audgen_mclk);
        repeat (16) @(posedge audgen_mclk);
        read_check(av_regs_pkg::reg_frame_cnt, 32'(vs_count), 1'b0);
        apb_write(av_regs_pkg::reg_ctrl, model_ctrl & ~32'h1, 1'b0);
        while (vs_count < 3) @(posedge audgen_mclk);
        repeat (16) @(posedge audgen_mclk);
        read_check(av_regs_pkg::reg_frame_cnt, 32'(vs_count), 1'b0);

        $display("errors: register %0d, video %0d, audio %0d", err_reg, err_vid, err_aud);
        if (err_reg + err_vid + err_aud == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
av_timing_pkg.sv
av_regs_pkg.sv
apb_regs.sv
video_timing.sv
i2s_tx.sv
av_core_top.sv
tb_av_core.sv

// ==== Makefile ====
# Verilator build and run of the av core testbench

VERILATOR ?= verilator
TOP       ?= tb_av_core
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

# sources named in the file list, so a change triggers a rebuild
SOURCES := $(shell grep -v '^+' $(FLIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(OBJ_DIR)/V%: $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FLIST) --Mdir $(OBJ_DIR) -o V$*

# the log decides pass or fail
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qx "all tests passed" $(LOG); then \
		echo "RESULT: PASS"; \
	else \
		echo "RESULT: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
